// ==== logic/obj_consts.svh ====
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// Object table geometry
`define OBJ_ENTRIES 128
`define OBJ_WORDS   8

// Fixed sprite width in pixels
`define OBJ_WIDTH   16

// Visible lines per frame
`define VIS_LINES   224

// A bottom value at or above this ends the sprite list
`define LIST_END    8'hF0

`endif

// ==== logic/obj_types_pkg.sv ====
package obj_types_pkg;

    // Object table entry, one word each
    //   word 0  top in [7:0], bottom in [15:8]
    //   word 1  xpos in [8:0]
    //   word 2  signed pitch
    //   word 3  start offset, MSB is the horizontal flip
    //   word 4  pal in [13:8], bank in [6:4], prio in [1:0]
    //   word 7  scratch row offset, kept by the scanner
    typedef logic [15:0] obj_word_t;
    typedef logic [9:0]  obj_addr_t;   // {entry, word index}
    typedef logic [6:0]  obj_idx_t;
    typedef logic [19:0] rom_addr_t;   // {bank, offset}

    typedef logic [1:0]  prio_t;
    typedef logic [5:0]  pal_t;
    typedef logic [3:0]  pen_t;        // 0 is transparent

    typedef enum logic [2:0] {
        scan_idle, scan_test, scan_read_x, scan_read_pitch,
        scan_read_offs, scan_read_attr, scan_write_scr, scan_draw
    } obj_scan_state_t;

endpackage

// ==== logic/video_pkg.sv ====
package video_pkg;

    // Current render line
    typedef logic [8:0] line_t;

    // Horizontal position, wraps at 512
    typedef logic [8:0] scr_x_t;

    // {prio, pal, pen}, all zero means no sprite pixel
    typedef logic [11:0] pixel_t;

    // Which bank takes sprite writes this line
    typedef enum logic {
        lb_wr_a,
        lb_wr_b
    } lb_state_t;

endpackage

// ==== logic/obj_if.sv ====
`timescale 1ns/1ps

// Scanner access to the object table
interface obj_tbl_if import obj_types_pkg::*; ();
    obj_addr_t addr;
    obj_word_t dout;   // Registered, one cycle after addr
    obj_word_t din;
    logic      we;

    modport scan (output addr, output din, output we, input dout);
    modport mem  (input addr, input din, input we, output dout);
endinterface

// One draw command from scanner to drawer
interface obj_draw_if import obj_types_pkg::*, video_pkg::*; ();
    logic       start;   // Single-cycle pulse
    logic       busy;
    scr_x_t     xpos;
    obj_word_t  offset;  // Row offset, MSB set when flipped
    logic [3:0] bank;
    prio_t      prio;
    pal_t       pal;
    logic       hflip;

    modport cmd (
        output start, output xpos, output offset, output bank,
        output prio, output pal, output hflip,
        input  busy
    );
    modport eng (
        input  start, input xpos, input offset, input bank,
        input  prio, input pal, input hflip,
        output busy
    );
endinterface

// ==== logic/obj_table.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_table import obj_types_pkg::*; (
    input  logic      clk,

    input  obj_addr_t cpu_addr,
    input  obj_word_t cpu_din,
    input  logic      cpu_we,
    output obj_word_t cpu_dout,

    obj_tbl_if.mem    tbl
);

    localparam int DEPTH = `OBJ_ENTRIES * `OBJ_WORDS;

    obj_word_t ram [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            ram[cpu_addr] <= cpu_din;
        end
        // Scanner write comes last so it wins a same-address clash
        if (tbl.we) begin
            ram[tbl.addr] <= tbl.din;
        end
        cpu_dout <= ram[cpu_addr];
        tbl.dout <= ram[tbl.addr];
    end

    // Only the scratch word is ever written back by the scanner
    a_scratch_only: assert property (
        @(posedge clk) tbl.we |-> tbl.addr[2:0] == 3'd7
    ) else $error("scanner write outside scratch word, addr %h", tbl.addr);

endmodule

// ==== logic/obj_scan.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_scan import obj_types_pkg::*, video_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    flip,
    input  logic    hstart,
    input  line_t   vrender,

    obj_tbl_if.scan tbl,
    obj_draw_if.cmd drw
);

    obj_scan_state_t state;
    obj_idx_t        cur_obj;
    logic [2:0]      idx;
    logic            stall;     // Table read for a new address still in flight
    logic            first;     // Sprite starts on this line
    obj_word_t       pitch;
    obj_word_t       start_offs;
    obj_word_t       row_offs;
    line_t           vrf;
    logic [7:0]      top, bottom;
    logic            in_zone, line_ok;
    logic            advance;

    assign vrf     = flip ? line_t'(`VIS_LINES - 1) - vrender : vrender;
    assign line_ok = vrf < `VIS_LINES;

    // Empty when top >= bottom, so such entries never match
    assign top     = tbl.dout[7:0];
    assign bottom  = tbl.dout[15:8];
    assign in_zone = vrf[7:0] >= top && bottom > vrf[7:0];

    // Word 7 carries the running offset except on the top line
    assign row_offs = first ? start_offs : tbl.dout;

    assign tbl.addr = {cur_obj, idx};
    assign tbl.we   = state == scan_write_scr;
    assign tbl.din  = row_offs + pitch;

    // Move on to the next entry
    always_comb begin
        advance = 1'b0;
        if (state == scan_test) begin
            advance = !stall && bottom < `LIST_END && !in_zone;
        end else if (state == scan_draw) begin
            advance = !drw.busy;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= scan_idle;
            cur_obj   <= '0;
            idx       <= '0;
            stall     <= 1'b0;
            drw.start <= 1'b0;
        end else begin
            drw.start <= 1'b0;
            stall     <= 1'b0;
            idx       <= (idx >= 3'd4) ? 3'd7 : idx + 3'd1;  // After attr go to scratch
            if (hstart) begin
                cur_obj <= '0;
                if (!line_ok) begin
                    state <= scan_idle;
                    idx   <= '0;
                end else begin
                    state <= scan_test;
                    // Word 0 of entry 0 is not on the bus yet
                    idx   <= '0;
                    stall <= 1'b1;
                end
            end else begin
                case (state)
                    scan_idle: idx <= '0;
                    scan_test: begin
                        if (!stall) begin
                            if (bottom >= `LIST_END) begin
                                state <= scan_idle;           // End of list
                            end else if (in_zone) begin
                                state <= scan_read_x;
                            end
                        end
                    end
                    scan_read_x:     state <= scan_read_pitch;
                    scan_read_pitch: state <= scan_read_offs;
                    scan_read_offs:  state <= scan_read_attr;
                    scan_read_attr:  state <= scan_write_scr;
                    scan_write_scr:  state <= scan_draw;
                    scan_draw: begin
                        if (!drw.busy) begin
                            drw.start <= 1'b1;
                        end
                    end
                    default: state <= scan_idle;
                endcase
                if (advance) begin
                    if (cur_obj == obj_idx_t'(`OBJ_ENTRIES - 1)) begin
                        state <= scan_idle;
                    end else begin
                        cur_obj <= cur_obj + 1'b1;
                        idx     <= '0;
                        stall   <= 1'b1;
                        state   <= scan_test;
                    end
                end
            end
        end
    end

    // Entry fields, captured as each word comes back
    always_ff @(posedge clk) begin
        case (state)
            scan_test:       first <= top == vrf[7:0];
            scan_read_x:     drw.xpos <= tbl.dout[8:0];
            scan_read_pitch: pitch <= tbl.dout;
            scan_read_offs:  start_offs <= tbl.dout;
            scan_read_attr: begin
                drw.pal  <= tbl.dout[13:8];
                drw.bank <= {1'b0, tbl.dout[6:4]};
                drw.prio <= tbl.dout[1:0];
            end
            scan_write_scr: begin
                drw.offset <= row_offs;
                drw.hflip  <= row_offs[15];
            end
            default: ;
        endcase
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) drw.start |-> !drw.busy
    ) else $error("draw start while drawer busy");

endmodule

// ==== logic/obj_draw.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_draw import obj_types_pkg::*, video_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    obj_draw_if.eng   drw,

    output rom_addr_t rom_addr,
    input  obj_word_t rom_data,

    output scr_x_t    wr_x,
    output pixel_t    wr_pix,
    output logic      wr_en
);

    localparam int LAST_WORD = `OBJ_WIDTH / 4 - 1;

    logic       busy;
    logic [1:0] word_cnt;
    logic [2:0] phase;      // 0..2 fetch, 3..6 pixel writes
    obj_word_t  offs;
    logic [3:0] bank;
    prio_t      prio;
    pal_t       pal;
    logic       hflip;
    obj_word_t  pens;
    scr_x_t     x;
    pen_t       pen;
    logic [1:0] word_sel;
    logic       writing;

    assign drw.busy = busy;

    // Flipped sprites walk the words backwards
    assign word_sel = word_cnt ^ {2{hflip}};
    assign rom_addr = {bank, {1'b0, offs[14:0]} + {14'd0, word_sel}};

    assign pen     = pens[15:12];          // Leftmost pen first
    assign writing = busy && phase >= 3'd3;
    assign wr_x    = x;
    assign wr_pix  = {prio, pal, pen};
    assign wr_en   = writing && pen != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            phase    <= '0;
            word_cnt <= '0;
        end else if (!busy) begin
            if (drw.start) begin
                busy     <= 1'b1;
                phase    <= '0;
                word_cnt <= '0;
            end
        end else if (phase == 3'd6) begin
            phase <= '0;
            if (word_cnt == 2'(LAST_WORD)) begin
                busy <= 1'b0;                   // Last pixel went out this cycle
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && drw.start) begin
            offs  <= drw.offset;
            bank  <= drw.bank;
            prio  <= drw.prio;
            pal   <= drw.pal;
            hflip <= drw.hflip;
            x     <= drw.xpos;
        end else if (busy && phase == 3'd2) begin
            // ROM word is valid now
            pens <= hflip ? {rom_data[3:0], rom_data[7:4], rom_data[11:8], rom_data[15:12]}
                          : rom_data;
        end else if (writing) begin
            pens <= pens << 4;
            x    <= x + 1'b1;                   // Wraps at 512
        end
    end

endmodule

// ==== logic/obj_line_buf.sv ====
`timescale 1ns/1ps

module obj_line_buf import video_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   hstart,

    input  scr_x_t wr_x,
    input  pixel_t wr_pix,
    input  logic   wr_en,

    input  scr_x_t rd_x,
    output pixel_t pix
);

    lb_state_t lb_state;
    logic      wr_bank;
    logic      rd_bank;
    pixel_t    stored;
    logic      take_new;

    pixel_t    mem [0:1][0:511];

    assign wr_bank = lb_state == lb_wr_b;
    assign rd_bank = ~wr_bank;

    // Lower entries draw first, so a tie keeps the old pixel
    assign stored   = mem[wr_bank][wr_x];
    assign take_new = stored == '0 || wr_pix[11:10] > stored[11:10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lb_state <= lb_wr_a;
        end else if (hstart) begin
            lb_state <= (lb_state == lb_wr_a) ? lb_wr_b : lb_wr_a;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && take_new) begin
            mem[wr_bank][wr_x] <= wr_pix;
        end
        pix               <= mem[rd_bank][rd_x];
        mem[rd_bank][rd_x] <= '0;           // Leave the bank empty for reuse
    end

endmodule

// ==== logic/obj_top.sv ====
`timescale 1ns/1ps

module obj_top import obj_types_pkg::*, video_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // CPU side of the object table
    input  obj_addr_t cpu_addr,
    input  obj_word_t cpu_din,
    input  logic      cpu_we,
    output obj_word_t cpu_dout,

    // Video timing
    input  logic      flip,
    input  logic      hstart,
    input  line_t     vrender,

    // Pattern ROM, two-cycle read
    output rom_addr_t rom_addr,
    input  obj_word_t rom_data,

    // Line playback
    input  scr_x_t    rd_x,
    output pixel_t    pix
);

    obj_tbl_if  tbl_bus ();
    obj_draw_if draw_bus ();

    scr_x_t wr_x;
    pixel_t wr_pix;
    logic   wr_en;

    obj_table u_obj_table (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .tbl      (tbl_bus.mem)
    );

    obj_scan u_obj_scan (
        .clk     (clk),
        .rst     (rst),
        .flip    (flip),
        .hstart  (hstart),
        .vrender (vrender),
        .tbl     (tbl_bus.scan),
        .drw     (draw_bus.cmd)
    );

    obj_draw u_obj_draw (
        .clk      (clk),
        .rst      (rst),
        .drw      (draw_bus.eng),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .wr_x     (wr_x),
        .wr_pix   (wr_pix),
        .wr_en    (wr_en)
    );

    obj_line_buf u_obj_line_buf (
        .clk    (clk),
        .rst    (rst),
        .hstart (hstart),
        .wr_x   (wr_x),
        .wr_pix (wr_pix),
        .wr_en  (wr_en),
        .rd_x   (rd_x),
        .pix    (pix)
    );

endmodule

// ==== verif/obj_tb.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_tb import obj_types_pkg::*, video_pkg::*; ();

    localparam int    LINE_WAIT      = 1200;
    localparam int    CYCLES_PER_REC = 2500;
    localparam int    SCREEN_W       = 512;
    localparam line_t IDLE_LINE      = 9'h1F0;   // Beyond the visible area
    localparam string TRACE_PATH     = "verif/obj_trace.txt";

    logic      clk;
    logic      rst;
    obj_addr_t cpu_addr;
    obj_word_t cpu_din;
    logic      cpu_we;
    obj_word_t cpu_dout;
    logic      flip;
    logic      hstart;
    line_t     vrender;
    rom_addr_t rom_addr;
    rom_addr_t rom_addr_q;
    rom_addr_t rom_addr_d2;
    obj_word_t rom_data;
    scr_x_t    rd_x;
    pixel_t    pix;

    // Trace records, kind plus two hex fields
    logic [7:0]  rec_kind [$];
    int unsigned rec_a [$];
    int unsigned rec_b [$];
    int          rec_count;
    logic        trace_loaded;

    // Expected playback of the line under test
    pixel_t exp_pix [0:SCREEN_W-1];
    logic   exp_valid [0:SCREEN_W-1];
    logic   line_open;

    obj_top u_obj_top (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rd_x     (rd_x),
        .pix      (pix)
    );

    always #5 clk = ~clk;

    // Pattern word at A holds pens A+1..A+4, leftmost first
    function automatic obj_word_t rom_word(input rom_addr_t a);
        obj_word_t w;
        for (int k = 0; k < 4; k++) begin
            w[15 - 4 * k -: 4] = 4'(a + rom_addr_t'(k + 1));
        end
        return w;
    endfunction

    // Two-cycle ROM
    always @(posedge clk) begin
        rom_addr_q  <= rom_addr;
        rom_addr_d2 <= rom_addr_q;
    end

    always @(posedge clk) begin
        #1;
        rom_data = rom_word(rom_addr_d2);
    end

    task automatic stop_with_fail();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_with_fail();
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic load_trace();
        int          fd;
        int          code;
        string       text;
        logic [7:0]  kind_ch;
        int unsigned a;
        int unsigned b;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_PATH);
            stop_with_fail();
        end
        while (!$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) == 0) continue;
            code = $sscanf(text, "%c %h %h", kind_ch, a, b);
            if (code <= 0 || kind_ch == "#" || kind_ch == "\n") continue;  // Comment or blank
            if (code != 3) begin
                $display("Trace line could not be parsed: %s", text);
                stop_with_fail();
            end
            rec_kind.push_back(kind_ch);
            rec_a.push_back(a);
            rec_b.push_back(b);
        end
        $fclose(fd);
        rec_count = rec_kind.size();
    endtask

    task automatic table_write(input int unsigned addr, input int unsigned data);
        cpu_addr = obj_addr_t'(addr);
        cpu_din  = obj_word_t'(data);
        cpu_we   = 1'b1;
        tick();
        cpu_we   = 1'b0;
    endtask

    task automatic check_scratch(input int unsigned entry, input int unsigned value);
        if (entry >= `OBJ_ENTRIES) begin
            $display("Trace asks for scratch of entry %0d, which does not exist", entry);
            stop_with_fail();
        end
        cpu_addr = obj_addr_t'(entry * `OBJ_WORDS + 7);
        tick();
        assert (cpu_dout == obj_word_t'(value)) else
            report_error($sformatf("scratch of entry %0d is %04h, expected %04h",
                                   entry, cpu_dout, value));
    endtask

    task automatic start_line(input int unsigned line, input int unsigned flipped);
        vrender = line_t'(line);
        flip    = flipped[0];
        hstart  = 1'b1;
        tick();
        hstart  = 1'b0;
        line_open = 1'b1;
    endtask

    // Let the scan finish, swap banks on an idle line, play the line back
    task automatic finish_line();
        if (line_open) begin
            repeat (LINE_WAIT) tick();
            vrender = IDLE_LINE;
            flip    = 1'b0;
            hstart  = 1'b1;
            tick();
            hstart  = 1'b0;
            for (int x = 0; x < SCREEN_W; x++) begin
                rd_x = scr_x_t'(x);
                tick();
                if (exp_valid[x]) begin
                    assert (pix == exp_pix[x]) else
                        report_error($sformatf("pixel at x=%03h is %03h, expected %03h",
                                               x, pix, exp_pix[x]));
                end
            end
            // Played-back locations must now read empty
            for (int x = 0; x < SCREEN_W; x++) begin
                if (exp_valid[x] && exp_pix[x] != '0) begin
                    rd_x = scr_x_t'(x);
                    tick();
                    assert (pix == '0) else
                        report_error($sformatf("pixel at x=%03h not cleared, reads %03h",
                                               x, pix));
                end
            end
            for (int x = 0; x < SCREEN_W; x++) begin
                exp_valid[x] = 1'b0;
                exp_pix[x]   = '0;
            end
            line_open = 1'b0;
        end
    endtask

    task automatic run_trace();
        for (int i = 0; i < rec_count; i++) begin
            case (rec_kind[i])
                "W": begin
                    finish_line();
                    table_write(rec_a[i], rec_b[i]);
                end
                "L": begin
                    finish_line();
                    start_line(rec_a[i], rec_b[i]);
                end
                "P": begin
                    exp_pix[rec_a[i] % SCREEN_W]   = pixel_t'(rec_b[i]);
                    exp_valid[rec_a[i] % SCREEN_W] = 1'b1;
                end
                "S": begin
                    finish_line();
                    check_scratch(rec_a[i], rec_b[i]);
                end
                default: begin
                    $display("Trace record %0d has an unknown kind", i);
                    stop_with_fail();
                end
            endcase
        end
        finish_line();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_addr     = '0;
        cpu_din      = '0;
        cpu_we       = 1'b0;
        flip         = 1'b0;
        hstart       = 1'b0;
        vrender      = IDLE_LINE;
        rd_x         = '0;
        rom_data     = '0;
        line_open    = 1'b0;
        rec_count    = 0;
        trace_loaded = 1'b0;
        for (int x = 0; x < SCREEN_W; x++) begin
            exp_valid[x] = 1'b0;
            exp_pix[x]   = '0;
        end
        load_trace();
        trace_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        run_trace();
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog scaled by the trace length
    initial begin
        wait (trace_loaded);
        repeat (rec_count * CYCLES_PER_REC) @(posedge clk);
        $display("Timeout, the trace did not complete within %0d cycles",
                 rec_count * CYCLES_PER_REC);
        stop_with_fail();
    end

endmodule

// ==== verif/obj_trace.txt ====
# Columns: kind, field a (hex), field b (hex)
# W table addr data | L vrender flip | P x pixel | S entry scratch
W 000 3020
W 001 0010
W 002 0004
W 003 0100
W 004 0511
W 008 3020
W 009 01F8
W 00A 0004
W 00B 8100
W 00C 0511
W 010 2220
W 011 0018
W 012 0001
W 013 020C
W 014 0A22
W 018 2120
W 019 000C
W 01A 0008
W 01B 0300
W 01C 0731
W 020 1025
W 028 5040
W 030 F000
W 038 3020
W 039 00C0
W 03B 0100
W 03C 0511
L 020 0
P 00B 000
P 00C 471
P 010 451
P 013 454
P 018 8AD
P 01B 456
P 01E 456
P 01F 8A1
P 021 000
P 027 8A3
P 028 000
P 1F8 457
P 1F7 000
P 000 455
P 007 451
P 080 000
P 0A0 000
P 0C0 000
S 0 0104
S 1 8104
S 2 020D
S 3 0308
L 021 0
P 00C 000
P 010 455
P 013 458
P 018 8AE
P 01A 459
P 01B 8A1
P 01D 459
P 020 000
P 027 8A4
P 1F8 45B
P 007 455
S 0 0108
S 1 8108
S 2 020E
S 3 0308
L 0BD 1
P 010 459
P 018 45B
P 01A 45D
P 01F 45F
P 027 000
P 1F8 45F
P 007 459
S 0 010C
S 1 810C
S 2 020E

// ==== tb.f ====
+incdir+logic
logic/obj_types_pkg.sv
logic/video_pkg.sv
logic/obj_if.sv
logic/obj_table.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_line_buf.sv
logic/obj_top.sv
verif/obj_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module obj_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vobj_tb)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF "=== PASS ===" <<< "$sim_output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
